/* project.f */
tlb_pkg.sv
tlb_fence.sv
tlb_page.sv
tlb_check.sv
tlb_cache.sv
tlb_cache_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tlb_cache_tb -f project.f -o tlb_sim
./obj_dir/tlb_sim > sim.log 2>&1
cat sim.log
if grep -q "=== FAIL ===" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation passed"

/* tlb_cache_tb.sv */
`timescale 1ns/1ps

module tlb_cache_tb import tlb_pkg::*; ();

    localparam int clk_period = 20;
    localparam int n_random = 48;
    localparam int full_fence_cycles = l0_depth + 8;
    localparam int watchdog_cycles = n_random * 8 + 3 * full_fence_cycles + 300;
    localparam logic [31:0] lfsr_taps = 32'h80200003; // x^32 + x^22 + x^2 + x + 1.

    logic clk = 1'b0;
    logic rst, req, refill_valid, refill_level, fence_req, fence_all;
    logic [vpn_w-1:0] req_vpn, refill_vpn, fence_vpn, resp_vpn, miss_vpn;
    logic [1:0] req_access, priv_mode;
    logic resp_valid, resp_hit, resp_exception, resp_level, miss, fence_busy, fence_done;
    logic [ppn_w-1:0] resp_ppn;
    pte_u refill_pte;

    logic [31:0] lfsr = 32'he40b073e;
    int cycle = 0;
    int errors = 0;
    int checks = 0;
    int due_q[$];
    logic [44:0] exp_q[$]; // Hit, exception, level, PPN and VPN of each pending response.
    logic [44:0] exp_now;
    logic [vpn_w-1:0] used_q[$];

    // Model of the cache contents, keyed the same way as the two levels.
    logic m0_valid [l0_depth];
    logic [vpn_w-1:0] m0_vpn [l0_depth];
    logic [31:0] m0_pte [l0_depth];
    logic m1_valid [l1_depth];
    logic [vpn_part_w-1:0] m1_key [l1_depth];
    logic [31:0] m1_pte [l1_depth];

    tlb_cache dut_i (.*);

    always #(clk_period / 2) clk = ~clk;

    // Galois LFSR, stepped once for each bit taken.
    function automatic logic [31:0] draw(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ lfsr_taps) : (lfsr >> 1);
        end
        return val;
    endfunction

    // The PTE holds ppn in bits 31:10 and rsw in 9:8, then d a g u x w r v.
    function automatic logic entry_exception(input logic [31:0] pte, input logic level_one,
                                             input logic [1:0] access, input logic [1:0] mode);
        logic allowed;
        allowed = (access == access_load) ? pte[1] : (access == access_store) ? pte[2] : pte[3];
        if (!pte[0] || (pte[2] && !pte[1]) || pte[9:8] != 2'b00) return 1'b1;
        if (pte[3:1] == 3'b000) return 1'b0; // A pointer entry.
        if (!allowed || !pte[6] || (access == access_store && !pte[7])) return 1'b1;
        if ((mode == mode_user && !pte[4]) || (mode == mode_super && pte[4])) return 1'b1;
        return level_one && pte[19:10] != 10'd0;
    endfunction

    function automatic logic [24:0] expect_resp(input logic [vpn_w-1:0] vpn,
                                                input logic [1:0] access, input logic [1:0] mode);
        logic [5:0] i0;
        logic [3:0] i1;
        logic exc0, exc1, res0, res1;
        i0 = vpn[5:0];
        i1 = vpn[13:10];
        exc0 = entry_exception(m0_pte[i0], 1'b0, access, mode);
        exc1 = entry_exception(m1_pte[i1], 1'b1, access, mode);
        res0 = m0_valid[i0] && m0_vpn[i0] == vpn && (m0_pte[i0][3:1] != 3'b000 || exc0);
        res1 = m1_valid[i1] && m1_key[i1] == vpn[19:10] && (m1_pte[i1][3:1] != 3'b000 || exc1);
        if (res0) return {1'b1, exc0, 1'b0, m0_pte[i0][31:10]};
        if (res1) return {1'b1, exc1, 1'b1, m1_pte[i1][31:20], vpn[9:0]};
        return '0;
    endfunction

    task automatic lookup(input logic [vpn_w-1:0] vpn, input logic [1:0] access,
                          input logic [1:0] mode);
        @(posedge clk);
        req <= 1'b1;
        req_vpn <= vpn;
        req_access <= access;
        priv_mode <= mode;
        due_q.push_back(cycle + 3); // Seen by the compare on the third falling edge.
        exp_q.push_back({expect_resp(vpn, access, mode), vpn});
        used_q.push_back(vpn);
    endtask

    task automatic stop_requests();
        @(posedge clk);
        req <= 1'b0;
    endtask

    task automatic refill(input logic level, input logic [vpn_w-1:0] vpn, input logic [31:0] pte);
        @(posedge clk);
        req <= 1'b0;
        refill_valid <= 1'b1;
        refill_level <= level;
        refill_vpn <= vpn;
        refill_pte <= pte;
        @(posedge clk);
        refill_valid <= 1'b0;
        if (level) begin
            m1_valid[vpn[13:10]] = 1'b1;
            m1_key[vpn[13:10]] = vpn[19:10];
            m1_pte[vpn[13:10]] = pte;
        end else begin
            m0_valid[vpn[5:0]] = 1'b1;
            m0_vpn[vpn[5:0]] = vpn;
            m0_pte[vpn[5:0]] = pte;
        end
    endtask

    task automatic fence(input logic all, input logic [vpn_w-1:0] vpn);
        stop_requests();
        while (due_q.size() != 0) @(posedge clk);
        fence_req <= 1'b1;
        fence_all <= all;
        fence_vpn <= vpn;
        @(posedge clk);
        fence_req <= 1'b0;
        @(negedge clk);
        if (!fence_busy) begin
            errors++;
            $display("fence_busy did not rise the cycle after fence_req");
        end
        while (!fence_done) @(negedge clk);
        if (fence_busy) begin
            errors++;
            $display("fence_busy was still high when fence_done pulsed");
        end
        for (int i = 0; i < l0_depth; i++) begin
            if (all || (i == vpn[5:0] && m0_vpn[i] == vpn)) m0_valid[i] = 1'b0;
        end
        for (int i = 0; i < l1_depth; i++) begin
            if (all || (i == vpn[13:10] && m1_key[i] == vpn[19:10])) m1_valid[i] = 1'b0;
        end
    endtask

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        errors++;
        $display("Fail %s expected %h got %h", name, expected, actual);
    endtask

    always @(negedge clk) begin
        cycle = cycle + 1;
        if (miss !== (resp_valid & ~resp_hit)) report_value("miss", resp_valid & ~resp_hit, miss);
        if (due_q.size() != 0 && due_q[0] == cycle) begin
            exp_now = exp_q.pop_front();
            void'(due_q.pop_front());
            checks++;
            if (resp_valid !== 1'b1) begin
                errors++;
                $display("No response arrived for the request to VPN %h", exp_now[19:0]);
            end else begin
                if (resp_hit !== exp_now[44]) report_value("resp_hit", exp_now[44], resp_hit);
                if (resp_exception !== exp_now[43]) begin
                    report_value("resp_exception", exp_now[43], resp_exception);
                end
                if (resp_vpn !== exp_now[19:0]) report_value("resp_vpn", exp_now[19:0], resp_vpn);
                if (exp_now[44] && resp_level !== exp_now[42]) begin
                    report_value("resp_level", exp_now[42], resp_level);
                end
                if (exp_now[44] && resp_ppn !== exp_now[41:20]) begin
                    report_value("resp_ppn", exp_now[41:20], resp_ppn);
                end
                if (!exp_now[44] && miss_vpn !== exp_now[19:0]) begin
                    report_value("miss_vpn", exp_now[19:0], miss_vpn);
                end
            end
        end else if (resp_valid !== 1'b0) begin
            errors++;
            $display("A response arrived with no request due");
        end
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired after %0d cycles, errors: %0d", watchdog_cycles, errors);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] pte;
        logic [vpn_w-1:0] va;
        logic lvl;
        logic [1:0] acc;
        int n;
        rst = 1'b0;
        req = 1'b0;
        req_vpn = '0;
        req_access = access_load;
        priv_mode = mode_user;
        refill_valid = 1'b0;
        refill_level = 1'b0;
        refill_vpn = '0;
        refill_pte = '0;
        fence_req = 1'b0;
        fence_all = 1'b0;
        fence_vpn = '0;
        for (int i = 0; i < l0_depth; i++) {m0_valid[i], m0_vpn[i], m0_pte[i]} = '0;
        for (int i = 0; i < l1_depth; i++) {m1_valid[i], m1_key[i], m1_pte[i]} = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b1;

        // A user leaf at level 0, then VPNs that share its index.
        r = draw(20);
        va = r[19:0];
        r = draw(22);
        refill(1'b0, va, {r[21:0], 2'b00, 8'hdf});
        lookup(va, access_load, mode_user);
        lookup(va ^ 20'h00040, access_load, mode_user);
        lookup(va ^ 20'h80000, access_store, mode_user);

        // An aligned supervisor superpage over the same VPN[1].
        r = draw(12);
        refill(1'b1, va, {r[11:0], 10'd0, 2'b00, 8'hcf});
        r = draw(10);
        lookup({va[19:10], r[9:0]}, access_fetch, mode_super);
        lookup({va[19:10], ~va[9:0]}, access_store, mode_super);
        lookup(va, access_load, mode_user); // Both levels resolve here.

        repeat (n_random) begin
            r = draw(20);
            va = r[19:0];
            r = draw(22);
            pte[31:10] = r[21:0];
            r = draw(1);
            if (r[0]) pte[19:10] = 10'd0;
            r = draw(3);
            pte[9:8] = (r[2:0] == 3'd7) ? 2'b01 : 2'b00;
            r = draw(8);
            pte[7:0] = r[7:0];
            r = draw(2);
            pte[7:0] = pte[7:0] | {1'b0, r[1], 5'd0, r[0]}; // Favor v and a.
            r = draw(1);
            lvl = r[0];
            refill(lvl, va, pte);
            r = draw(2);
            acc = (r[1:0] == 2'b11) ? access_load : r[1:0];
            r = draw(11);
            lookup(lvl ? {va[19:10], r[9:0]} : va, acc, r[10] ? mode_super : mode_user);
        end

        // Fence one address and keep its neighbor.
        r = draw(20);
        va = r[19:0];
        refill(1'b0, va, {22'h2a5a5, 2'b00, 8'hdf});
        refill(1'b0, {va[19:6], 6'(va[5:0] + 6'd1)}, {22'h15a5a, 2'b00, 8'hdf});
        fence(1'b0, va);
        lookup(va, access_load, mode_user);
        lookup({va[19:6], 6'(va[5:0] + 6'd1)}, access_load, mode_user);

        fence(1'b1, '0);
        n = used_q.size();
        for (int i = 0; i < n; i++) lookup(used_q[i], access_load, mode_user);

        // A clean pointer entry at level 1 does not resolve.
        r = draw(20);
        va = r[19:0];
        refill(1'b1, va, {22'h00123, 2'b00, 8'h01});
        lookup(va, access_load, mode_super);
        stop_requests();

        while (due_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        $display("Errors: %0d, responses checked: %0d", errors, checks);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* tlb_cache.sv */
`timescale 1ns/1ps

module tlb_cache import tlb_pkg::*; (
    input logic clk,
    input logic rst,
    input logic req,
    input logic [vpn_w-1:0] req_vpn,
    input logic [1:0] req_access,
    input logic [1:0] priv_mode,
    output logic resp_valid,
    output logic resp_hit,
    output logic resp_exception,
    output logic resp_level,
    output logic [ppn_w-1:0] resp_ppn,
    output logic [vpn_w-1:0] resp_vpn,
    output logic miss,
    output logic [vpn_w-1:0] miss_vpn,
    input logic refill_valid,
    input logic refill_level,
    input logic [vpn_w-1:0] refill_vpn,
    input pte_u refill_pte,
    input logic fence_req,
    input logic fence_all,
    input logic [vpn_w-1:0] fence_vpn,
    output logic fence_busy,
    output logic fence_done
);

    logic accept;
    logic req_q;
    logic [vpn_w-1:0] vpn_q;
    logic [1:0] access_q;
    logic [1:0] mode_q;
    logic hit_l0, hit_l1;
    logic mis_l0, mis_l1;
    logic leaf_l0, leaf_l1;
    logic exc_l0, exc_l1;
    logic res_l0, res_l1;
    pte_u entry_l0, entry_l1;
    logic [ppn_w-1:0] ppn_l0, ppn_l1;

    // Refills and fences own the arrays, so a request then is dropped.
    assign accept = req & ~refill_valid & ~fence_busy;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_q <= 1'b0;
        end else begin
            req_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        vpn_q <= req_vpn;
        access_q <= req_access;
        mode_q <= priv_mode;
    end

    tlb_page #(.level(0)) page_l0 (
        .clk(clk), .rst(rst), .req(accept), .req_vpn(req_vpn),
        .refill_valid(refill_valid), .refill_level(refill_level),
        .refill_vpn(refill_vpn), .refill_pte(refill_pte),
        .fence_req(fence_req), .fence_all(fence_all), .fence_vpn(fence_vpn),
        .hit(hit_l0), .entry(entry_l0), .misaligned(mis_l0),
        .fence_busy(fence_busy), .fence_done(fence_done)
    );

    // Level 1 sweeps fewer sets and always finishes before level 0.
    tlb_page #(.level(1)) page_l1 (
        .clk(clk), .rst(rst), .req(accept), .req_vpn(req_vpn),
        .refill_valid(refill_valid), .refill_level(refill_level),
        .refill_vpn(refill_vpn), .refill_pte(refill_pte),
        .fence_req(fence_req), .fence_all(fence_all), .fence_vpn(fence_vpn),
        .hit(hit_l1), .entry(entry_l1), .misaligned(mis_l1),
        .fence_busy(), .fence_done()
    );

    tlb_check check_l0 (
        .entry(entry_l0), .level_one(1'b0), .misaligned(mis_l0),
        .req_vpn(vpn_q), .req_access(access_q), .priv_mode(mode_q),
        .leaf(leaf_l0), .exception(exc_l0), .ppn(ppn_l0)
    );

    tlb_check check_l1 (
        .entry(entry_l1), .level_one(1'b1), .misaligned(mis_l1),
        .req_vpn(vpn_q), .req_access(access_q), .priv_mode(mode_q),
        .leaf(leaf_l1), .exception(exc_l1), .ppn(ppn_l1)
    );

    // A clean pointer entry does not resolve and leaves the walk to the walker.
    assign res_l0 = hit_l0 & (leaf_l0 | exc_l0);
    assign res_l1 = hit_l1 & (leaf_l1 | exc_l1);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            resp_valid <= 1'b0;
            miss <= 1'b0;
        end else begin
            resp_valid <= req_q;
            miss <= req_q & ~(res_l0 | res_l1);
        end
    end

    always_ff @(posedge clk) begin
        if (req_q) begin
            resp_hit <= res_l0 | res_l1;
            resp_exception <= res_l0 ? exc_l0 : (res_l1 & exc_l1); // Level 0 wins.
            resp_level <= ~res_l0 & res_l1;
            resp_ppn <= res_l0 ? ppn_l0 : ppn_l1;
            resp_vpn <= vpn_q;
            miss_vpn <= vpn_q;
        end
    end

endmodule

/* tlb_check.sv */
`timescale 1ns/1ps

module tlb_check import tlb_pkg::*; (
    input pte_u entry,
    input logic level_one,
    input logic misaligned,
    input logic [vpn_w-1:0] req_vpn,
    input logic [1:0] req_access,
    input logic [1:0] priv_mode,
    output logic leaf,
    output logic exception,
    output logic [ppn_w-1:0] ppn
);

    logic is_read;
    logic is_write;
    logic is_fetch;
    logic format_fail;
    logic perm_fail;
    logic mode_fail;
    logic flag_fail;
    logic align_fail;

    assign is_read = |(req_access & access_load);
    assign is_write = |(req_access & access_store);
    assign is_fetch = (req_access == access_fetch);

    // An entry with none of r, w, x points to the next level.
    assign leaf = entry.leaf.r | entry.leaf.w | entry.leaf.x;

    // These apply to pointer entries as well as leaves.
    assign format_fail = ~entry.leaf.v |
                         (entry.leaf.w & ~entry.leaf.r) |
                         (|entry.leaf.rsw);

    assign perm_fail = ~((entry.leaf.r & is_read) |
                         (entry.leaf.w & is_write) |
                         (entry.leaf.x & is_fetch));

    // User pages are closed to supervisor mode and the reverse.
    assign mode_fail = ((priv_mode == mode_user) & ~entry.leaf.u) |
                       ((priv_mode == mode_super) & entry.leaf.u);

    assign flag_fail = ~entry.leaf.a | (is_write & ~entry.leaf.d);

    assign align_fail = level_one & misaligned;

    assign exception = format_fail |
                       (leaf & (perm_fail | mode_fail | flag_fail | align_fail));

    // A superpage keeps the low half of the VPN as the low half of the PPN.
    assign ppn = level_one ? {entry.leaf.ppn1, req_vpn[vpn_part_w-1:0]} : entry.flat.ppn;

endmodule

/* tlb_page.sv */
`timescale 1ns/1ps

module tlb_page import tlb_pkg::*; #(
    parameter int level = 0
) (
    input logic clk,
    input logic rst,
    input logic req,
    input logic [vpn_w-1:0] req_vpn,
    input logic refill_valid,
    input logic refill_level,
    input logic [vpn_w-1:0] refill_vpn,
    input pte_u refill_pte,
    input logic fence_req,
    input logic fence_all,
    input logic [vpn_w-1:0] fence_vpn,
    output logic hit,
    output pte_u entry,
    output logic misaligned,
    output logic fence_busy,
    output logic fence_done
);

    localparam int depth = (level == 0) ? l0_depth : l1_depth;
    localparam int idx_w = $clog2(depth);
    localparam int tag_w = (level == 0) ? l0_tag_w : l1_tag_w;

    // The part of the VPN this level is keyed by, right aligned.
    function automatic logic [vpn_w-1:0] level_key(input logic [vpn_w-1:0] vpn);
        return (level == 0) ? vpn : vpn_w'(vpn[vpn_w-1:vpn_part_w]);
    endfunction

    logic [vpn_w-1:0] req_key;
    logic [vpn_w-1:0] refill_key;
    logic [vpn_w-1:0] fence_key;
    logic [idx_w-1:0] ram_idx;
    logic [tag_w-1:0] refill_tag;
    logic [tag_w-1:0] cmp_tag;
    logic [tag_w-1:0] rd_tag;
    logic [depth-1:0] valid_q;
    logic [depth-1:0] mis_q;
    logic [tag_w-1:0] tag_q [depth];
    pte_u pte_mem [depth];
    logic rd_valid;
    logic rd_mis;
    logic req_q;
    logic fence_port;
    logic refill_we;
    logic refill_mis;
    logic tag_match;
    logic sweep_read;
    logic sweep_clear;
    logic [fence_idx_w-1:0] sweep_idx;
    logic [tag_w-1:0] sweep_tag;

    assign req_key = level_key(req_vpn);
    assign refill_key = level_key(refill_vpn);
    assign fence_key = level_key(fence_vpn);

    // The fence owns the array port while it sweeps, then refill, then lookup.
    assign fence_port = sweep_read | sweep_clear;
    assign ram_idx = fence_port ? sweep_idx[idx_w-1:0] :
                     refill_valid ? refill_key[idx_w-1:0] : req_key[idx_w-1:0];

    assign refill_tag = refill_key[idx_w +: tag_w];
    assign refill_we = refill_valid & (refill_level == 1'(level)) & ~fence_port;
    assign refill_mis = (level == 1) && (refill_pte.leaf.ppn0 != '0); // Superpage not aligned.

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
            req_q <= 1'b0;
        end else begin
            req_q <= req;
            if (refill_we) begin
                valid_q[ram_idx] <= 1'b1;
            end
            if (sweep_clear) begin
                valid_q[ram_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (refill_we) begin
            tag_q[ram_idx] <= refill_tag;
            mis_q[ram_idx] <= refill_mis;
            pte_mem[ram_idx] <= refill_pte;
        end
        rd_valid <= valid_q[ram_idx];
        rd_tag <= tag_q[ram_idx];
        rd_mis <= mis_q[ram_idx];
        entry <= pte_mem[ram_idx];
        cmp_tag <= sweep_read ? sweep_tag : req_key[idx_w +: tag_w];
    end

    // The same compare serves both the lookup and the by-address fence.
    assign tag_match = rd_valid & (rd_tag == cmp_tag);
    assign hit = req_q & tag_match;
    assign misaligned = rd_mis;

    tlb_fence #(
        .depth(depth),
        .tag_w(tag_w)
    ) fence_i (
        .clk(clk),
        .rst(rst),
        .fence_req(fence_req),
        .fence_all(fence_all),
        .fence_idx_in(fence_idx_w'(fence_key[idx_w-1:0])),
        .fence_tag_in(fence_key[idx_w +: tag_w]),
        .tag_match(tag_match),
        .sweep_read(sweep_read),
        .sweep_clear(sweep_clear),
        .sweep_idx(sweep_idx),
        .sweep_tag(sweep_tag),
        .busy(fence_busy),
        .done(fence_done)
    );

endmodule

/* tlb_fence.sv */
`timescale 1ns/1ps

module tlb_fence import tlb_pkg::*; #(
    parameter int depth = 64,
    parameter int tag_w = 14
) (
    input logic clk,
    input logic rst,
    input logic fence_req,
    input logic fence_all,
    input logic [fence_idx_w-1:0] fence_idx_in,
    input logic [tag_w-1:0] fence_tag_in,
    input logic tag_match,
    output logic sweep_read,
    output logic sweep_clear,
    output logic [fence_idx_w-1:0] sweep_idx,
    output logic [tag_w-1:0] sweep_tag,
    output logic busy,
    output logic done
);

    logic [1:0] state;
    logic sweep_all;

    // A single address is read in REQ and cleared in WE if the stored tag matched.
    assign sweep_read = (state == state_req) & ~sweep_all;
    assign sweep_clear = ((state == state_req) & sweep_all) | ((state == state_we) & tag_match);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= state_idle;
            sweep_idx <= '0;
            sweep_all <= 1'b0;
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= (state == state_end);
            case (state)
                state_idle: begin
                    if (fence_req) begin
                        sweep_idx <= fence_all ? '0 : fence_idx_in;
                        sweep_all <= fence_all;
                        busy <= 1'b1;
                        state <= state_req;
                    end
                end
                state_req: begin
                    if (!sweep_all) begin
                        state <= state_we;
                    end else if (sweep_idx == fence_idx_w'(depth - 1)) begin
                        state <= state_end;
                    end else begin
                        sweep_idx <= sweep_idx + 1'b1; // One set per cycle.
                    end
                end
                state_we: state <= state_end;
                default: begin
                    state <= state_idle;
                    busy <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == state_idle && fence_req) begin
            sweep_tag <= fence_tag_in;
        end
    end

endmodule

/* tlb_pkg.sv */
package tlb_pkg;

    // Sv32 virtual and physical page number geometry.
    localparam int vpn_w = 20;
    localparam int vpn_part_w = 10;
    localparam int ppn_w = 22;
    localparam int ppn1_w = 12;
    localparam int ppn0_w = 10;

    // Level 0 is keyed by the full VPN, level 1 by VPN[1] only.
    localparam int l0_depth = 64;
    localparam int l1_depth = 16;
    localparam int l0_tag_w = 14;
    localparam int l1_tag_w = 6;

    localparam int fence_idx_w = 6; // Wide enough for the level 0 sweep.

    // Bit 0 is a read, bit 1 is a write.
    localparam logic [1:0] access_fetch = 2'b00;
    localparam logic [1:0] access_load = 2'b01;
    localparam logic [1:0] access_store = 2'b10;

    localparam logic [1:0] mode_user = 2'b00;
    localparam logic [1:0] mode_super = 2'b01;

    // Fence sweep states.
    localparam logic [1:0] state_idle = 2'd0;
    localparam logic [1:0] state_req = 2'd1;
    localparam logic [1:0] state_we = 2'd2;
    localparam logic [1:0] state_end = 2'd3;

    // One PTE word. The leaf view splits the PPN for superpages and exposes the flags,
    // the flat view treats the PPN as a single number.
    typedef union packed {
        struct packed {
            logic [ppn1_w-1:0] ppn1;
            logic [ppn0_w-1:0] ppn0;
            logic [1:0] rsw;
            logic d;
            logic a;
            logic g;
            logic u;
            logic x;
            logic w;
            logic r;
            logic v;
        } leaf;
        struct packed {
            logic [ppn_w-1:0] ppn;
            logic [1:0] rsw;
            logic [7:0] flags;
        } flat;
    } pte_u;

endpackage
